/* hdl/sha256_pkg.sv */
/*
 * SHA-256 sizes, memory address widths and the padded block type
 */

package sha256_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int WORD_BITS     = 32;
    localparam int MAX_MSG_BYTES = 55;  // keeps padding inside one block
    localparam int MSG_ADDR_BITS = 6;
    localparam int NUM_ROUNDS    = 64;
    localparam int K_ADDR_BITS   = 6;
    localparam int NUM_H         = 8;
    localparam int H_ADDR_BITS   = 3;
    localparam int STATE_BITS    = NUM_H * WORD_BITS;  // word 0 in the top bits
    localparam int BLOCK_BYTES   = 64;
    localparam int SCHED_WORDS   = 16;

    // ----------------------------------------
    // padded block
    // ----------------------------------------
    // The padder fills it byte by byte and the schedule reads it as big-endian
    // words. Both views use ascending ranges, so element 0 is the leftmost one
    // and byte 0 is the top byte of word 0.
    typedef union packed {
        logic [0:BLOCK_BYTES-1][7:0]           bytes;
        logic [0:SCHED_WORDS-1][WORD_BITS-1:0] words;
    } msg_block_t;

endpackage

/* hdl/msg_padder.sv */
/*
 * message byte reader and 512-bit block padding
 */

`timescale 1ns/1ps

module msg_padder (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  go,
    input  logic [sha256_pkg::MSG_ADDR_BITS-1:0]  msg_length,
    input  logic [7:0]                            msg_data,
    input  logic                                  finish,
    output logic [sha256_pkg::MSG_ADDR_BITS-1:0]  msg_address,
    output logic                                  msg_enable,
    output sha256_pkg::msg_block_t                block,
    output logic                                  block_ready
);

    logic                                  idle;
    logic [sha256_pkg::MSG_ADDR_BITS-1:0]  len;
    logic                                  byte_valid;  // read data arrives this cycle
    logic [sha256_pkg::MSG_ADDR_BITS-1:0]  byte_addr;   // where that byte goes

    // ----------------------------------------
    // read sequencing
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            idle        <= 1'b1;
            msg_enable  <= 1'b0;
            msg_address <= '0;
            byte_valid  <= 1'b0;
            block_ready <= 1'b0;
        end
        else
        begin
            byte_valid <= msg_enable;
            if (go && idle)
            begin
                idle        <= 1'b0;
                msg_enable  <= (msg_length != '0);  // empty message skips reads
                msg_address <= '0;
                block_ready <= 1'b0;
            end
            else
            begin
                if (finish)
                    idle <= 1'b1;
                if (msg_enable)
                begin
                    if (msg_address == len - 1'b1)
                        msg_enable <= 1'b0;
                    else
                        msg_address <= msg_address + 1'b1;
                end
                // last byte lands on this same edge
                if (!idle && !msg_enable)
                    block_ready <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // block contents
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        byte_addr <= msg_address;
        if (go && idle)
        begin
            len                      <= msg_length;
            block                    <= '0;
            block.bytes[msg_length]  <= 8'h80;  // the appended 1 bit
            {block.bytes[sha256_pkg::BLOCK_BYTES-2], block.bytes[sha256_pkg::BLOCK_BYTES-1]}
                <= 16'({msg_length, 3'b000});  // bit length, big-endian
        end
        else if (byte_valid)
            block.bytes[byte_addr] <= msg_data;
    end

endmodule

/* hdl/hash_loader.sv */
/*
 * initial hash reader, fills the 256-bit state from the H memory
 */

`timescale 1ns/1ps

module hash_loader (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                go,
    input  logic [sha256_pkg::WORD_BITS-1:0]    hmem_data,
    input  logic                                finish,
    output logic [sha256_pkg::H_ADDR_BITS-1:0]  hmem_address,
    output logic                                hmem_enable,
    output logic [sha256_pkg::STATE_BITS-1:0]   init_state,
    output logic                                state_ready
);

    logic                                idle;
    logic                                cap_valid;
    logic [sha256_pkg::H_ADDR_BITS-1:0]  cap_slot;  // word index of arriving data

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            idle         <= 1'b1;
            hmem_enable  <= 1'b0;
            hmem_address <= '0;
            cap_valid    <= 1'b0;
            state_ready  <= 1'b0;
        end
        else
        begin
            cap_valid <= hmem_enable;
            if (go && idle)
            begin
                idle         <= 1'b0;
                hmem_enable  <= 1'b1;
                hmem_address <= '0;
                state_ready  <= 1'b0;
            end
            else
            begin
                if (finish)
                    idle <= 1'b1;
                if (hmem_enable)
                begin
                    if (int'(hmem_address) == sha256_pkg::NUM_H - 1)
                        hmem_enable <= 1'b0;
                    else
                        hmem_address <= hmem_address + 1'b1;
                end
                if (cap_valid && int'(cap_slot) == sha256_pkg::NUM_H - 1)
                    state_ready <= 1'b1;  // eighth word captured
            end
        end
    end

    always_ff @(posedge clock)
    begin
        cap_slot <= hmem_address;
        if (cap_valid)
            init_state[(sha256_pkg::NUM_H - 1 - int'(cap_slot)) * sha256_pkg::WORD_BITS
                       +: sha256_pkg::WORD_BITS] <= hmem_data;
    end

endmodule

/* hdl/msg_schedule.sv */
/*
 * round counter, K memory reads and the message schedule window
 */

`timescale 1ns/1ps

module msg_schedule (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                block_ready,
    input  logic                                state_ready,
    input  sha256_pkg::msg_block_t              block,
    input  logic [sha256_pkg::WORD_BITS-1:0]    kmem_data,
    output logic [sha256_pkg::K_ADDR_BITS-1:0]  kmem_address,
    output logic                                kmem_enable,
    output logic                                round_valid,
    output logic                                last_round,
    output logic [sha256_pkg::WORD_BITS-1:0]    w_word,
    output logic [sha256_pkg::WORD_BITS-1:0]    k_word
);

    logic                                                          both_q;
    logic                                                          start;
    logic                                                          at_last;
    logic [0:sha256_pkg::SCHED_WORDS-1][sha256_pkg::WORD_BITS-1:0] win;  // W[t] .. W[t+15]
    logic [sha256_pkg::WORD_BITS-1:0]                              s0;
    logic [sha256_pkg::WORD_BITS-1:0]                              s1;
    logic [sha256_pkg::WORD_BITS-1:0]                              w_next;

    assign start   = block_ready && state_ready && !both_q;  // first cycle both are up
    assign at_last = (int'(kmem_address) == sha256_pkg::NUM_ROUNDS - 1);
    assign k_word  = kmem_data;  // K arrives aligned with round_valid

    // ----------------------------------------
    // W[t+16] from W[t], W[t+1], W[t+9], W[t+14]
    // ----------------------------------------
    always_comb
    begin
        s0     = {win[1][6:0], win[1][31:7]} ^ {win[1][17:0], win[1][31:18]} ^ (win[1] >> 3);
        s1     = {win[14][16:0], win[14][31:17]} ^ {win[14][18:0], win[14][31:19]}
                 ^ (win[14] >> 10);
        w_next = win[0] + s0 + win[9] + s1;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            both_q       <= 1'b0;
            kmem_enable  <= 1'b0;
            kmem_address <= '0;
            round_valid  <= 1'b0;
            last_round   <= 1'b0;
        end
        else
        begin
            both_q      <= block_ready && state_ready;
            round_valid <= kmem_enable;  // one cycle read latency
            last_round  <= kmem_enable && at_last;
            if (start)
            begin
                kmem_enable  <= 1'b1;
                kmem_address <= '0;
            end
            else if (kmem_enable)
            begin
                if (at_last)
                    kmem_enable <= 1'b0;
                else
                    kmem_address <= kmem_address + 1'b1;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (start)
            win <= block.words;
        else if (kmem_enable)
            win <= {win[1:sha256_pkg::SCHED_WORDS-1], w_next};  // slide by one round
        w_word <= win[0];
    end

endmodule

/* hdl/compress_round.sv */
/*
 * working variables a to h, one compression round per cycle,
 * final addition of the initial hash
 */

`timescale 1ns/1ps

module compress_round (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               round_valid,
    input  logic                               last_round,
    input  logic [sha256_pkg::WORD_BITS-1:0]   w_word,
    input  logic [sha256_pkg::WORD_BITS-1:0]   k_word,
    input  logic [sha256_pkg::STATE_BITS-1:0]  init_state,
    output logic [sha256_pkg::STATE_BITS-1:0]  digest,
    output logic                               digest_valid
);

    logic                               running;  // past round 0
    logic [sha256_pkg::STATE_BITS-1:0]  work;     // a in the top word
    logic [sha256_pkg::WORD_BITS-1:0]   a, b, c, d, e, f, g, h;
    logic [sha256_pkg::WORD_BITS-1:0]   sum0;
    logic [sha256_pkg::WORD_BITS-1:0]   sum1;
    logic [sha256_pkg::WORD_BITS-1:0]   ch;
    logic [sha256_pkg::WORD_BITS-1:0]   maj;
    logic [sha256_pkg::WORD_BITS-1:0]   t1;
    logic [sha256_pkg::WORD_BITS-1:0]   t2;

    // round 0 starts straight from the loaded hash
    assign {a, b, c, d, e, f, g, h} = running ? work : init_state;

    // ----------------------------------------
    // round function
    // ----------------------------------------
    always_comb
    begin
        sum0 = {a[1:0], a[31:2]} ^ {a[12:0], a[31:13]} ^ {a[21:0], a[31:22]};
        sum1 = {e[5:0], e[31:6]} ^ {e[10:0], e[31:11]} ^ {e[24:0], e[31:25]};
        ch   = (e & f) ^ (~e & g);
        maj  = (a & b) ^ (a & c) ^ (b & c);
        t1   = h + sum1 + ch + k_word + w_word;
        t2   = sum0 + maj;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            running      <= 1'b0;
            digest_valid <= 1'b0;
        end
        else
        begin
            digest_valid <= round_valid && last_round;
            if (round_valid)
                running <= !last_round;
        end
    end

    always_ff @(posedge clock)
    begin
        if (round_valid)
            work <= {t1 + t2, a, b, c, d + t1, e, f, g};
    end

    // wordwise add, no carry between words
    always_comb
    begin
        for (int i = 0; i < sha256_pkg::NUM_H; i++)
            digest[i*sha256_pkg::WORD_BITS +: sha256_pkg::WORD_BITS] =
                work[i*sha256_pkg::WORD_BITS +: sha256_pkg::WORD_BITS]
                + init_state[i*sha256_pkg::WORD_BITS +: sha256_pkg::WORD_BITS];
    end

endmodule

/* hdl/digest_writer.sv */
/*
 * ordered write-out of the 8 digest words and the finish pulse
 */

`timescale 1ns/1ps

module digest_writer (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                digest_valid,
    input  logic [sha256_pkg::STATE_BITS-1:0]   digest,
    output logic [sha256_pkg::H_ADDR_BITS-1:0]  dom_address,
    output logic [sha256_pkg::WORD_BITS-1:0]    dom_data,
    output logic                                dom_enable,
    output logic                                dom_write,
    output logic                                finish
);

    logic [sha256_pkg::STATE_BITS-1:0]  held;  // words still to write, next on top
    logic                               at_last;

    assign at_last = (int'(dom_address) == sha256_pkg::NUM_H - 1);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            dom_enable  <= 1'b0;
            dom_write   <= 1'b0;
            dom_address <= '0;
            finish      <= 1'b0;
        end
        else
        begin
            finish <= dom_enable && at_last;  // cycle after the last write
            if (digest_valid)
            begin
                dom_enable  <= 1'b1;
                dom_write   <= 1'b1;
                dom_address <= '0;
            end
            else if (dom_enable)
            begin
                if (at_last)
                begin
                    dom_enable <= 1'b0;
                    dom_write  <= 1'b0;
                end
                else
                    dom_address <= dom_address + 1'b1;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (digest_valid)
        begin
            dom_data <= digest[sha256_pkg::STATE_BITS-1 -: sha256_pkg::WORD_BITS];
            held     <= digest << sha256_pkg::WORD_BITS;
        end
        else if (dom_enable)
        begin
            dom_data <= held[sha256_pkg::STATE_BITS-1 -: sha256_pkg::WORD_BITS];
            held     <= held << sha256_pkg::WORD_BITS;
        end
    end

endmodule

/* hdl/sha256_top.sv */
/*
 * SHA-256 single block top level
 * padder, hash loader, schedule, rounds and digest writer on the memory ports
 */

`timescale 1ns/1ps

module sha256_top (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  go,
    input  logic [sha256_pkg::MSG_ADDR_BITS-1:0]  msg_length,
    output logic                                  finish,

    output logic [sha256_pkg::MSG_ADDR_BITS-1:0]  msg_address,
    output logic                                  msg_enable,
    input  logic [7:0]                            msg_data,

    output logic [sha256_pkg::K_ADDR_BITS-1:0]    kmem_address,
    output logic                                  kmem_enable,
    input  logic [sha256_pkg::WORD_BITS-1:0]      kmem_data,

    output logic [sha256_pkg::H_ADDR_BITS-1:0]    hmem_address,
    output logic                                  hmem_enable,
    input  logic [sha256_pkg::WORD_BITS-1:0]      hmem_data,

    output logic [sha256_pkg::H_ADDR_BITS-1:0]    dom_address,
    output logic [sha256_pkg::WORD_BITS-1:0]      dom_data,
    output logic                                  dom_enable,
    output logic                                  dom_write
);

    sha256_pkg::msg_block_t                block;
    logic                                  block_ready;
    logic [sha256_pkg::STATE_BITS-1:0]     init_state;
    logic                                  state_ready;
    logic                                  round_valid;
    logic                                  last_round;
    logic [sha256_pkg::WORD_BITS-1:0]      w_word;
    logic [sha256_pkg::WORD_BITS-1:0]      k_word;
    logic [sha256_pkg::STATE_BITS-1:0]     digest;
    logic                                  digest_valid;

    msg_padder u_padder (
        .clock       (clock),
        .reset       (reset),
        .go          (go),
        .msg_length  (msg_length),
        .msg_data    (msg_data),
        .finish      (finish),
        .msg_address (msg_address),
        .msg_enable  (msg_enable),
        .block       (block),
        .block_ready (block_ready)
    );

    hash_loader u_loader (
        .clock        (clock),
        .reset        (reset),
        .go           (go),
        .hmem_data    (hmem_data),
        .finish       (finish),
        .hmem_address (hmem_address),
        .hmem_enable  (hmem_enable),
        .init_state   (init_state),
        .state_ready  (state_ready)
    );

    msg_schedule u_schedule (
        .clock        (clock),
        .reset        (reset),
        .block_ready  (block_ready),
        .state_ready  (state_ready),
        .block        (block),
        .kmem_data    (kmem_data),
        .kmem_address (kmem_address),
        .kmem_enable  (kmem_enable),
        .round_valid  (round_valid),
        .last_round   (last_round),
        .w_word       (w_word),
        .k_word       (k_word)
    );

    compress_round u_rounds (
        .clock        (clock),
        .reset        (reset),
        .round_valid  (round_valid),
        .last_round   (last_round),
        .w_word       (w_word),
        .k_word       (k_word),
        .init_state   (init_state),
        .digest       (digest),
        .digest_valid (digest_valid)
    );

    digest_writer u_writer (
        .clock        (clock),
        .reset        (reset),
        .digest_valid (digest_valid),
        .digest       (digest),
        .dom_address  (dom_address),
        .dom_data     (dom_data),
        .dom_enable   (dom_enable),
        .dom_write    (dom_write),
        .finish       (finish)
    );

endmodule

/* tb/sha256_asserts.sv */
/*
 * concurrent checks on the top level strobes
 */

`timescale 1ns/1ps

module sha256_asserts (
    input logic                                  clock,
    input logic                                  reset,
    input logic                                  finish,
    input logic                                  dom_enable,
    input logic                                  dom_write,
    input logic                                  msg_enable,
    input logic [sha256_pkg::MSG_ADDR_BITS-1:0]  msg_address
);

    finish_single: assert property (@(posedge clock) disable iff (reset)
        finish |=> !finish)
        else $error("finish high on two consecutive cycles");

    write_enabled: assert property (@(posedge clock) disable iff (reset)
        dom_write |-> dom_enable)
        else $error("dom_write high while dom_enable is low");

    // message reads stay inside the longest message
    msg_in_range: assert property (@(posedge clock) disable iff (reset)
        msg_enable |-> int'(msg_address) < sha256_pkg::MAX_MSG_BYTES)
        else $error("msg_address beyond the longest message");

endmodule

/* tb/sha256_model.svh */
/*
 * SHA-256 round constants, standard initial hash and a one-block reference digest
 */

`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

localparam logic [0:63][31:0] K_TABLE = {
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

localparam logic [255:0] H_STD = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
};

function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
endfunction

// pads len bytes of msg into one block and hashes it from h_init
function automatic logic [255:0] sha256_ref(input logic [0:63][7:0] msg, input int len,
                                            input logic [255:0] h_init);
    logic [7:0]   blk [64];
    logic [31:0]  w [64];
    logic [31:0]  v [8];
    logic [31:0]  s0;
    logic [31:0]  s1;
    logic [31:0]  t1;
    logic [31:0]  t2;
    logic [63:0]  bit_len;
    logic [255:0] result;
    bit_len = 64'(len) << 3;
    for (int i = 0; i < 64; i++)
        blk[i] = (i < len) ? msg[i] : ((i == len) ? 8'h80 : 8'h00);
    for (int i = 0; i < 8; i++)
        blk[56 + i] = bit_len[63 - 8*i -: 8];  // length big-endian at the end
    for (int t = 0; t < 16; t++)
        w[t] = {blk[4*t], blk[4*t + 1], blk[4*t + 2], blk[4*t + 3]};
    for (int t = 16; t < 64; t++)
    begin
        s0   = rotr(w[t-15], 7) ^ rotr(w[t-15], 18) ^ (w[t-15] >> 3);
        s1   = rotr(w[t-2], 17) ^ rotr(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + s0 + w[t-7] + s1;
    end
    for (int i = 0; i < 8; i++)
        v[i] = h_init[255 - 32*i -: 32];
    for (int t = 0; t < 64; t++)
    begin
        s1   = rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25);
        t1   = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + K_TABLE[t] + w[t];
        s0   = rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22);
        t2   = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
        v[7] = v[6];
        v[6] = v[5];
        v[5] = v[4];
        v[4] = v[3] + t1;
        v[3] = v[2];
        v[2] = v[1];
        v[1] = v[0];
        v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++)
        result[255 - 32*i -: 32] = v[i] + h_init[255 - 32*i -: 32];
    return result;
endfunction

`endif

/* tb/sha256_tb.sv */
/*
 * sha256_top testbench with memory models, LFSR stimulus, directed tests and watchdog
 */

`timescale 1ns/1ps

module sha256_tb;

    `include "sha256_model.svh"

    localparam int NUM_RUNS        = 16;  // 2 known + 10 random + 1 custom H + 3 chained
    localparam int WATCHDOG_CYCLES = NUM_RUNS * 200 + 100;
    localparam int RUN_LIMIT       = 300;

    logic                                  clock;
    logic                                  reset;
    logic                                  go;
    logic [sha256_pkg::MSG_ADDR_BITS-1:0]  msg_length;
    logic                                  finish;
    logic [sha256_pkg::MSG_ADDR_BITS-1:0]  msg_address;
    logic                                  msg_enable;
    logic [7:0]                            msg_data = 8'h00;
    logic [sha256_pkg::K_ADDR_BITS-1:0]    kmem_address;
    logic                                  kmem_enable;
    logic [sha256_pkg::WORD_BITS-1:0]      kmem_data = '0;
    logic [sha256_pkg::H_ADDR_BITS-1:0]    hmem_address;
    logic                                  hmem_enable;
    logic [sha256_pkg::WORD_BITS-1:0]      hmem_data = '0;
    logic [sha256_pkg::H_ADDR_BITS-1:0]    dom_address;
    logic [sha256_pkg::WORD_BITS-1:0]      dom_data;
    logic                                  dom_enable;
    logic                                  dom_write;

    logic [0:63][7:0]                      msg_mem;
    logic [31:0]                           kmem [64];
    logic [31:0]                           hmem [8];
    logic [sha256_pkg::MSG_ADDR_BITS-1:0]  msg_addr_q;
    logic [sha256_pkg::K_ADDR_BITS-1:0]    k_addr_q;
    logic [sha256_pkg::H_ADDR_BITS-1:0]    h_addr_q;
    logic                                  msg_en_q;
    logic                                  k_en_q;
    logic                                  h_en_q;
    logic [31:0]                           lfsr_state = 32'he0de4517;
    int                                    cycle = 0;

    sha256_top i_dut (.*);

    bind sha256_top sha256_asserts i_asserts (
        .clock       (clock),
        .reset       (reset),
        .finish      (finish),
        .dom_enable  (dom_enable),
        .dom_write   (dom_write),
        .msg_enable  (msg_enable),
        .msg_address (msg_address)
    );

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ----------------------------------------
    // memory models with one cycle read latency
    // ----------------------------------------
    always @(posedge clock)
    begin
        cycle      <= cycle + 1;
        msg_addr_q <= msg_address;
        msg_en_q   <= msg_enable;
        k_addr_q   <= kmem_address;
        k_en_q     <= kmem_enable;
        h_addr_q   <= hmem_address;
        h_en_q     <= hmem_enable;
    end

    always @(negedge clock)
    begin
        msg_data  <= msg_en_q ? msg_mem[msg_addr_q] : 8'h00;
        kmem_data <= k_en_q ? kmem[k_addr_q] : '0;
        hmem_data <= h_en_q ? hmem[h_addr_q] : '0;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Mismatch at %0d ns: %s expected %0h, got %0h",
                                $time, name, expected, actual));
    endtask

    task automatic load_h(input logic [255:0] h);
        for (int i = 0; i < 8; i++)
            hmem[i] = h[255 - 32*i -: 32];
    endtask

    task automatic fill_random();
        for (int i = 0; i < 64; i++)
            msg_mem[i] = 8'(rand_bits(8));  // bytes past the length too
    endtask

    // one go and the write-out up to finish
    task automatic hash_run(input int len, input logic [255:0] expected);
        int           writes;
        int           first_cycle;
        int           last_cycle;
        int           waited;
        logic [255:0] got;
        writes      = 0;
        first_cycle = 0;
        last_cycle  = 0;
        waited      = 0;
        got         = '0;
        @(negedge clock);
        go         = 1'b1;
        msg_length = 6'(len);
        @(negedge clock);
        go = 1'b0;
        while (!finish)
        begin
            if (dom_enable && dom_write)
            begin
                if (writes == 0)
                    first_cycle = cycle;
                check_value("dom_address", 256'(writes), 256'(dom_address));
                check_value("write cycle", 256'(first_cycle + writes), 256'(cycle));
                got        = {got[223:0], dom_data};
                last_cycle = cycle;
                writes++;
            end
            if (waited == RUN_LIMIT)
                abort_run($sformatf("no finish within %0d cycles of go", RUN_LIMIT));
            waited++;
            @(negedge clock);
        end
        check_value("write count", 256'(sha256_pkg::NUM_H), 256'(writes));
        check_value("finish cycle", 256'(last_cycle + 1), 256'(cycle));
        for (int i = 0; i < 8; i++)
            check_value($sformatf("dom_data word %0d", i),
                        256'(expected[255 - 32*i -: 32]), 256'(got[255 - 32*i -: 32]));
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic check_reset_quiet();
        repeat (20)
        begin
            @(negedge clock);
            check_value("finish", '0, 256'(finish));
            check_value("msg_enable", '0, 256'(msg_enable));
            check_value("kmem_enable", '0, 256'(kmem_enable));
            check_value("hmem_enable", '0, 256'(hmem_enable));
            check_value("dom_enable", '0, 256'(dom_enable));
            check_value("dom_write", '0, 256'(dom_write));
        end
    endtask

    task automatic run_known_vectors();
        load_h(H_STD);
        hash_run(0, 256'he3b0c44298fc1c149afbf4c8996fb92427ae41e4649b934ca495991b7852b855);
        msg_mem[0] = 8'h61;  // "abc"
        msg_mem[1] = 8'h62;
        msg_mem[2] = 8'h63;
        hash_run(3, 256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad);
    endtask

    task automatic run_random_messages(input int runs);
        int len;
        for (int r = 0; r < runs; r++)
        begin
            len = 1 + int'(rand_bits(6) % 32'd55);
            fill_random();
            hash_run(len, sha256_ref(msg_mem, len, H_STD));
        end
    endtask

    task automatic hash_with_random_h();
        logic [255:0] h;
        for (int i = 0; i < 8; i++)
            h[255 - 32*i -: 32] = rand_bits(32);
        load_h(h);
        fill_random();
        hash_run(sha256_pkg::MAX_MSG_BYTES, sha256_ref(msg_mem, sha256_pkg::MAX_MSG_BYTES, h));
        load_h(H_STD);
    endtask

    initial
    begin
        reset      = 1'b1;
        go         = 1'b0;
        msg_length = '0;
        msg_mem    = '0;
        for (int i = 0; i < 64; i++)
            kmem[i] = K_TABLE[i];
        load_h(H_STD);
        repeat (10) @(negedge clock);
        reset = 1'b0;
        check_reset_quiet();
        run_known_vectors();
        run_random_messages(10);
        hash_with_random_h();
        run_random_messages(3);  // chained runs with each go right after finish
        $display("TB PASSED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        abort_run("watchdog expired before the tests completed");
    end

endmodule

/* flist.f */
+incdir+tb
hdl/sha256_pkg.sv
hdl/msg_padder.sv
hdl/hash_loader.sv
hdl/msg_schedule.sv
hdl/compress_round.sv
hdl/digest_writer.sv
hdl/sha256_top.sv
tb/sha256_asserts.sv
tb/sha256_tb.sv

/* run.sh */
#!/bin/sh
# builds and runs the SHA-256 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sha256_tb -f flist.f -o sha256_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sha256_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^TB PASSED$'; then
    exit 0
fi
echo "pass message not found"
exit 1
